// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP ?= tb_laser310
RTL_TOP ?= laser310_top
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Simulation completed successfully
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
hdl/laser310_mem_pkg.sv
hdl/laser310_kbd_pkg.sv
hdl/cpu_timing.sv
hdl/reset_control.sv
hdl/addr_decode.sv
hdl/system_ram.sv
hdl/io_port.sv
hdl/keyboard_matrix.sv
hdl/laser310_top.sv
tests/tb_laser310.sv

// ==== hdl/addr_decode.sv ====
module addr_decode (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  laser310_mem_pkg::addr_t cpu_addr_i,
	input  logic cpu_mreq_i,
	input  logic cpu_rd_i,
	input  logic cpu_wr_i,
	input  logic mem_we_i,
	input  laser310_mem_pkg::data_t vram_q_i,
	input  laser310_mem_pkg::data_t ram_q_i,
	input  laser310_mem_pkg::data_t io_rd_data_i,
	output logic vram_we_o,
	output logic ram_we_o,
	output logic io_we_o,
	output laser310_mem_pkg::data_t cpu_di_o
);

	laser310_mem_pkg::region_t region;
	logic wr_cycle;
	logic any_we;

	// Only A15..A11 matter for the map
	always_comb
	begin
		casez (cpu_addr_i[15:11])
			5'b00???, 5'b010??: region = laser310_mem_pkg::REG_ROM;	// System and DOS ROM
			5'b01101: region = laser310_mem_pkg::REG_IO;
			5'b01110: region = laser310_mem_pkg::REG_VRAM;
			5'b01111, 5'b100??, 5'b1010?, 5'b10110: region = laser310_mem_pkg::REG_RAM;
			default: region = laser310_mem_pkg::REG_NONE;
		endcase
	end

	assign wr_cycle = mem_we_i && cpu_mreq_i && cpu_wr_i;
	assign vram_we_o = wr_cycle && (region == laser310_mem_pkg::REG_VRAM);
	assign ram_we_o = wr_cycle && (region == laser310_mem_pkg::REG_RAM);
	assign io_we_o = wr_cycle && (region == laser310_mem_pkg::REG_IO);
	assign any_we = vram_we_o || ram_we_o || io_we_o;

	always_comb
	begin
		if (!(cpu_mreq_i && cpu_rd_i))
			cpu_di_o = laser310_mem_pkg::BUS_FLOAT;
		else
		begin
			case (region)
				laser310_mem_pkg::REG_VRAM: cpu_di_o = vram_q_i;
				laser310_mem_pkg::REG_RAM: cpu_di_o = ram_q_i;
				laser310_mem_pkg::REG_IO: cpu_di_o = io_rd_data_i;
				default: cpu_di_o = laser310_mem_pkg::BUS_FLOAT;	// ROMs are gone
			endcase
		end
	end

	// One target per write, and the strobe never stretches past a clock
	a_single_we: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		any_we |-> ($onehot({vram_we_o, ram_we_o, io_we_o}) ##1 !any_we));

endmodule

// ==== hdl/cpu_timing.sv ====
module cpu_timing #(
	parameter int FRAME_CYCLES = 1000000,
	parameter int INT_CYCLES = 3200
) (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic mem_we_o,
	output logic cpu_int_n_o
);

	typedef enum logic [1:0]
	{
		ST_CLOCK,
		ST_WRITE,
		ST_LATCH,
		ST_WAIT
	} bus_state_t;

	localparam laser310_mem_pkg::phase_t PH_SAMPLE = 4'd3;	// Turbo decision point
	localparam laser310_mem_pkg::phase_t PH_LAST = 4'd13;	// End of a normal period
	localparam int FRAME_W = $clog2(FRAME_CYCLES);

	laser310_mem_pkg::phase_t phase;
	laser310_mem_pkg::phase_t phase_next;
	bus_state_t state;
	logic [FRAME_W-1:0] frame_cnt;

	always_comb
	begin
		if (phase == PH_LAST || (phase == PH_SAMPLE && turbo_i))
			phase_next = '0;
		else
			phase_next = phase + 4'd1;
	end

	// Starting from the last phase makes the first pulse follow reset
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase <= PH_LAST;
			state <= ST_WAIT;
		end
		else
		begin
			phase <= phase_next;
			case (phase_next)
				4'd0: state <= ST_CLOCK;
				4'd1: state <= ST_WRITE;
				4'd2: state <= ST_LATCH;	// Keyboard byte now visible
				default: state <= ST_WAIT;
			endcase
		end
	end

	assign cpu_clk_o = (state == ST_CLOCK);
	assign mem_we_o = (state == ST_WRITE);

	// Frame interrupt, low for the first INT_CYCLES counts
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			frame_cnt <= '0;
			cpu_int_n_o <= 1'b1;
		end
		else
		begin
			if (frame_cnt == FRAME_W'(FRAME_CYCLES - 1))
				frame_cnt <= '0;
			else
				frame_cnt <= frame_cnt + FRAME_W'(1);
			cpu_int_n_o <= (frame_cnt >= FRAME_W'(INT_CYCLES));
		end
	end

	// Write strobe trails the clock pulse by exactly one cycle
	a_clk_then_we: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		cpu_clk_o |-> (!mem_we_o ##1 (mem_we_o && !cpu_clk_o)));

endmodule

// ==== hdl/io_port.sv ====
module io_port (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic io_we_i,
	input  laser310_mem_pkg::data_t cpu_do_i,
	input  laser310_kbd_pkg::key_cols_t key_cols_i,
	input  logic cass_in_i,
	input  logic mem_we_i,
	output laser310_mem_pkg::data_t io_rd_data_o,
	output logic [1:0] speaker_o,
	output logic cass_out_o,
	output logic vdg_ag_o,
	output logic vdg_css_o
);

	laser310_mem_pkg::data_t out_latch;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			out_latch <= '0;
		else if (io_we_i)
			out_latch <= cpu_do_i;
	end

	// Bit 7 always reads high, cassette input is inverted
	always_ff @(posedge CLK50MHZ)
	begin
		if (mem_we_i)
			io_rd_data_o <= {1'b1, ~cass_in_i, key_cols_i};
	end

	assign speaker_o = {out_latch[laser310_mem_pkg::IO_LATCH_SPK_A],
		out_latch[laser310_mem_pkg::IO_LATCH_SPK_B]};
	assign cass_out_o = out_latch[laser310_mem_pkg::IO_LATCH_CASS];
	assign vdg_ag_o = out_latch[laser310_mem_pkg::IO_LATCH_AG];	// Graphics mode
	assign vdg_css_o = out_latch[laser310_mem_pkg::IO_LATCH_CSS];	// Colour set

endmodule

// ==== hdl/keyboard_matrix.sv ====
module keyboard_matrix (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic key_strobe_i,
	input  logic key_pressed_i,
	input  laser310_kbd_pkg::scan_code_t key_code_i,
	input  logic [7:0] row_sel_i,
	output laser310_kbd_pkg::key_cols_t key_cols_o,
	output logic key_reset_req_o
);

	laser310_kbd_pkg::key_matrix_t key_matrix;
	logic [6:0] slot;	// Valid flag and matrix bit

	// PS/2 set 2 code to matrix position
	function automatic logic [6:0] key_slot(input laser310_kbd_pkg::scan_code_t code);
		logic [5:0] bit_pos;
		logic hit;
		bit_pos = '0;
		hit = 1'b1;
		case (code)
			8'h2C: bit_pos = 6'd0;	// T
			8'h1D: bit_pos = 6'd1;	// W
			8'h24: bit_pos = 6'd3;	// E
			8'h15: bit_pos = 6'd4;	// Q
			8'h2D: bit_pos = 6'd5;	// R
			8'h34: bit_pos = 6'd8;	// G
			8'h1B: bit_pos = 6'd9;	// S
			laser310_kbd_pkg::SC_CTRL: bit_pos = 6'(laser310_kbd_pkg::KEY_CTRL_BIT);
			8'h23: bit_pos = 6'd11;	// D
			8'h1C: bit_pos = 6'd12;	// A
			8'h2B: bit_pos = 6'd13;	// F
			8'h32: bit_pos = 6'd16;	// B
			8'h22: bit_pos = 6'd17;	// X
			8'h12: bit_pos = 6'd18;	// Left shift
			8'h21: bit_pos = 6'd19;	// C
			8'h1A: bit_pos = 6'd20;	// Z
			8'h2A: bit_pos = 6'd21;	// V
			8'h2E: bit_pos = 6'd24;	// 5
			8'h1E: bit_pos = 6'd25;	// 2
			8'h26: bit_pos = 6'd27;	// 3
			8'h16: bit_pos = 6'd28;	// 1
			8'h25: bit_pos = 6'd29;	// 4
			8'h31: bit_pos = 6'd32;	// N
			8'h49: bit_pos = 6'd33;	// .
			8'h41: bit_pos = 6'd35;	// ,
			8'h29: bit_pos = 6'd36;	// Space
			8'h3A: bit_pos = 6'd37;	// M
			8'h36: bit_pos = 6'd40;	// 6
			8'h46: bit_pos = 6'd41;	// 9
			8'h4E: bit_pos = 6'd42;	// -
			8'h3E: bit_pos = 6'd43;	// 8
			8'h45: bit_pos = 6'd44;	// 0
			8'h3D: bit_pos = 6'd45;	// 7
			8'h35: bit_pos = 6'd48;	// Y
			8'h44: bit_pos = 6'd49;	// O
			8'h5A: bit_pos = 6'd50;	// Return
			8'h43: bit_pos = 6'd51;	// I
			8'h4D: bit_pos = 6'd52;	// P
			8'h3C: bit_pos = 6'd53;	// U
			8'h33: bit_pos = 6'd56;	// H
			8'h4B: bit_pos = 6'd57;	// L
			8'h52: bit_pos = 6'd58;	// Quote maps to colon
			8'h42: bit_pos = 6'd59;	// K
			8'h4C: bit_pos = 6'd60;	// ;
			8'h3B: bit_pos = 6'd61;	// J
			default: hit = 1'b0;
		endcase
		return {hit, bit_pos};
	endfunction

	assign slot = key_slot(key_code_i);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_matrix <= '1;
			key_reset_req_o <= 1'b0;
		end
		else
		begin
			// Ctrl must already be held when F12 goes down
			key_reset_req_o <= key_strobe_i && key_pressed_i
				&& (key_code_i == laser310_kbd_pkg::SC_F12)
				&& !key_matrix[laser310_kbd_pkg::KEY_CTRL_BIT];
			if (key_strobe_i && slot[6])
				key_matrix[slot[5:0]] <= ~key_pressed_i;
		end
	end

	// A low address bit selects its row, any pressed key pulls its column low
	always_comb
	begin
		key_cols_o = '1;
		for (int r = 0; r < laser310_kbd_pkg::KEY_ROWS; r++)
			for (int k = 0; k < laser310_kbd_pkg::KEY_COLS; k++)
				if (!row_sel_i[r] && !key_matrix[8*r+k])
					key_cols_o[k] = 1'b0;
	end

endmodule

// ==== hdl/laser310_kbd_pkg.sv ====
package laser310_kbd_pkg;

	typedef logic [7:0] scan_code_t;

	// Active low, bit 8*row+column
	typedef logic [63:0] key_matrix_t;

	// Column read result KD5..KD0
	typedef logic [5:0] key_cols_t;

	localparam int KEY_ROWS = 8;
	localparam int KEY_COLS = 6;

	// PS/2 set 2 codes with a special meaning
	localparam scan_code_t SC_CTRL = 8'h14;
	localparam scan_code_t SC_F12 = 8'h07;

	// Ctrl sits in row 1, column 2
	localparam int KEY_CTRL_BIT = 10;

endpackage

// ==== hdl/laser310_mem_pkg.sv ====
package laser310_mem_pkg;

	// CPU bus
	typedef logic [15:0] addr_t;
	typedef logic [7:0] data_t;

	// Bus cycle position inside one CPU clock period
	typedef logic [3:0] phase_t;

	// Decoded memory regions
	typedef enum logic [2:0]
	{
		REG_ROM,
		REG_IO,
		REG_VRAM,
		REG_RAM,
		REG_NONE
	} region_t;

	localparam int VRAM_ADDR_W = 11;	// 2 KB at 7000
	localparam int RAM_ADDR_W = 14;		// 16 KB at 7800

	// Bit positions in the 6800 output latch
	localparam int IO_LATCH_SPK_A = 0;
	localparam int IO_LATCH_CASS = 2;
	localparam int IO_LATCH_AG = 3;
	localparam int IO_LATCH_CSS = 4;
	localparam int IO_LATCH_SPK_B = 5;

	localparam data_t BUS_FLOAT = 8'hFF;	// Nothing drives the bus

endpackage

// ==== hdl/laser310_top.sv ====
module laser310_top #(
	parameter int FRAME_CYCLES = 1000000,
	parameter int INT_CYCLES = 3200,
	parameter int RESET_HOLD_CYCLES = 65536
) (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  laser310_mem_pkg::addr_t cpu_addr_i,
	input  laser310_mem_pkg::data_t cpu_do_i,
	input  logic cpu_mreq_i,
	input  logic cpu_rd_i,
	input  logic cpu_wr_i,
	input  logic turbo_i,
	input  logic cass_in_i,
	input  logic key_strobe_i,
	input  logic key_pressed_i,
	input  laser310_kbd_pkg::scan_code_t key_code_i,
	output logic cpu_clk_o,
	output laser310_mem_pkg::data_t cpu_di_o,
	output logic cpu_int_n_o,
	output logic cpu_reset_n_o,
	output logic [1:0] speaker_o,
	output logic cass_out_o,
	output logic vdg_ag_o,
	output logic vdg_css_o
);

	logic mem_we;
	logic vram_we;
	logic ram_we;
	logic io_we;
	logic key_reset_req;
	laser310_mem_pkg::data_t vram_q;
	laser310_mem_pkg::data_t ram_q;
	laser310_mem_pkg::data_t io_rd_data;
	laser310_kbd_pkg::key_cols_t key_cols;

	cpu_timing #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.INT_CYCLES(INT_CYCLES)
	) timing_inst (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.turbo_i(turbo_i),
		.cpu_clk_o(cpu_clk_o),
		.mem_we_o(mem_we),
		.cpu_int_n_o(cpu_int_n_o)
	);

	reset_control #(
		.RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
	) reset_inst (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.key_reset_req_i(key_reset_req),
		.cpu_reset_n_o(cpu_reset_n_o)
	);

	addr_decode decode_inst (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.cpu_addr_i(cpu_addr_i),
		.cpu_mreq_i(cpu_mreq_i),
		.cpu_rd_i(cpu_rd_i),
		.cpu_wr_i(cpu_wr_i),
		.mem_we_i(mem_we),
		.vram_q_i(vram_q),
		.ram_q_i(ram_q),
		.io_rd_data_i(io_rd_data),
		.vram_we_o(vram_we),
		.ram_we_o(ram_we),
		.io_we_o(io_we),
		.cpu_di_o(cpu_di_o)
	);

	// Video RAM 7000-77FF
	system_ram #(
		.ADDR_W(laser310_mem_pkg::VRAM_ADDR_W)
	) vram_inst (
		.CLK50MHZ(CLK50MHZ),
		.we_i(vram_we),
		.addr_i(cpu_addr_i[laser310_mem_pkg::VRAM_ADDR_W-1:0]),
		.wdata_i(cpu_do_i),
		.q_o(vram_q)
	);

	// Base RAM 7800-B7FF folds onto 14 bits without overlap
	system_ram #(
		.ADDR_W(laser310_mem_pkg::RAM_ADDR_W)
	) ram_inst (
		.CLK50MHZ(CLK50MHZ),
		.we_i(ram_we),
		.addr_i(cpu_addr_i[laser310_mem_pkg::RAM_ADDR_W-1:0]),
		.wdata_i(cpu_do_i),
		.q_o(ram_q)
	);

	io_port io_inst (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.io_we_i(io_we),
		.cpu_do_i(cpu_do_i),
		.key_cols_i(key_cols),
		.cass_in_i(cass_in_i),
		.mem_we_i(mem_we),
		.io_rd_data_o(io_rd_data),
		.speaker_o(speaker_o),
		.cass_out_o(cass_out_o),
		.vdg_ag_o(vdg_ag_o),
		.vdg_css_o(vdg_css_o)
	);

	keyboard_matrix kbd_inst (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.key_strobe_i(key_strobe_i),
		.key_pressed_i(key_pressed_i),
		.key_code_i(key_code_i),
		.row_sel_i(cpu_addr_i[7:0]),	// Row strobes are A7..A0
		.key_cols_o(key_cols),
		.key_reset_req_o(key_reset_req)
	);

endmodule

// ==== hdl/reset_control.sv ====
module reset_control #(
	parameter int RESET_HOLD_CYCLES = 65536
) (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic key_reset_req_i,
	output logic cpu_reset_n_o
);

	localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);

	logic [1:0] rst_sync;
	logic [HOLD_W-1:0] hold_cnt;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			rst_sync <= 2'b00;
			hold_cnt <= '0;
		end
		else
		begin
			rst_sync <= {rst_sync[0], 1'b1};
			if (key_reset_req_i)
				hold_cnt <= HOLD_W'(RESET_HOLD_CYCLES);	// Restart on every request
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - HOLD_W'(1);
		end
	end

	assign cpu_reset_n_o = rst_sync[1] && (hold_cnt == '0);

endmodule

// ==== hdl/system_ram.sv ====
module system_ram #(
	parameter int ADDR_W = 11
) (
	input  logic CLK50MHZ,
	input  logic we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  laser310_mem_pkg::data_t wdata_i,
	output laser310_mem_pkg::data_t q_o
);

	laser310_mem_pkg::data_t mem [2**ADDR_W];

	// Read returns the old byte on a write clock
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		q_o <= mem[addr_i];
	end

endmodule

// ==== tests/laser310_stimulus.txt ====
# Operands in hex. W addr data, R addr expect, F addr count (random), V addr count
# K code pressed, T cass_in, S turbo, L (latch outputs), I low_clocks period, X hold_clocks
S 0
F 7000 10
V 7000 10
F 7800 20
V 7800 20
F B7E0 20
V B7E0 20
S 1
F 7400 10
V 7400 10
F 9000 20
V 9000 20
S 0
R 0000 FF
R 4000 FF
R 6000 FF
R C000 FF
W 0100 5A
R 0100 FF
W 6800 2D
L
W 6800 12
L
T 0
K 2C 1
R 68FE FE
R 68FD FF
T 1
R 68FE BE
K 2C 0
R 68FE BF
T 0
K 14 1
K 07 1
X 32
K 07 0
K 14 0
I 14 C8

// ==== tests/tb_laser310.sv ====
module tb_laser310;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_CYCLES = 200;
	localparam int INT_CYCLES = 20;
	localparam int RESET_HOLD_CYCLES = 50;
	localparam int NORMAL_PERIOD = 14;	// CPU clock period in system clocks
	localparam int TURBO_PERIOD = 4;
	localparam int WAIT_LIMIT = 1000;	// Clocks before a wait gives up
	localparam string STIM_FILE = "tests/laser310_stimulus.txt";

	logic CLK50MHZ;
	logic RESET_N;
	laser310_mem_pkg::addr_t cpu_addr;
	laser310_mem_pkg::data_t cpu_do;
	logic cpu_mreq;
	logic cpu_rd;
	logic cpu_wr;
	logic turbo;
	logic cass_in;
	logic key_strobe;
	logic key_pressed;
	laser310_kbd_pkg::scan_code_t key_code;
	logic cpu_clk;
	laser310_mem_pkg::data_t cpu_di;
	logic cpu_int_n;
	logic cpu_reset_n;
	logic [1:0] speaker;
	logic cass_out;
	logic vdg_ag;
	logic vdg_css;

	laser310_mem_pkg::data_t mem_model [65536];	// Expected RAM contents
	laser310_mem_pkg::data_t io_written;	// Last byte sent to 6800
	integer seed;
	int check_errors;
	int total_errors;
	int test_count;
	int failed_tests;
	logic timed_out;
	logic file_error;

	laser310_top #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.INT_CYCLES(INT_CYCLES),
		.RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
	) DUT (
		.CLK50MHZ(CLK50MHZ),
		.RESET_N(RESET_N),
		.cpu_addr_i(cpu_addr),
		.cpu_do_i(cpu_do),
		.cpu_mreq_i(cpu_mreq),
		.cpu_rd_i(cpu_rd),
		.cpu_wr_i(cpu_wr),
		.turbo_i(turbo),
		.cass_in_i(cass_in),
		.key_strobe_i(key_strobe),
		.key_pressed_i(key_pressed),
		.key_code_i(key_code),
		.cpu_clk_o(cpu_clk),
		.cpu_di_o(cpu_di),
		.cpu_int_n_o(cpu_int_n),
		.cpu_reset_n_o(cpu_reset_n),
		.speaker_o(speaker),
		.cass_out_o(cass_out),
		.vdg_ag_o(vdg_ag),
		.vdg_css_o(vdg_css)
	);

	initial
	begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	task automatic check_data(input string name, input laser310_mem_pkg::data_t got,
		input laser310_mem_pkg::data_t exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic check_latch(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic check_level(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	// Ends on the falling edge inside the pulse
	task automatic wait_pulse(output laser310_mem_pkg::data_t last_di, output int clocks);
		int n;
		last_di = '0;
		clocks = 0;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge CLK50MHZ);
			clocks++;
			if (cpu_clk)
				return;
			last_di = cpu_di;	// Still valid just before the next pulse
		end
		$display("Timeout: no CPU clock pulse within %0d clocks", WAIT_LIMIT);
		timed_out = 1'b1;
	endtask

	task automatic bus_cycle(input laser310_mem_pkg::addr_t addr,
		input laser310_mem_pkg::data_t data, input logic write,
		output laser310_mem_pkg::data_t rdata);
		laser310_mem_pkg::data_t idle_di;
		int idle_clocks;
		int period_clocks;
		rdata = '0;
		wait_pulse(idle_di, idle_clocks);
		if (timed_out)
			return;
		cpu_addr = addr;
		cpu_do = data;
		cpu_mreq = 1'b1;
		cpu_rd = !write;
		cpu_wr = write;
		wait_pulse(rdata, period_clocks);	// Bus held for one whole period
		cpu_mreq = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		if (!timed_out)
			check_level("cpu_clk_o period", period_clocks,
				turbo ? TURBO_PERIOD : NORMAL_PERIOD);
	endtask

	task automatic write_byte(input laser310_mem_pkg::addr_t addr,
		input laser310_mem_pkg::data_t data);
		laser310_mem_pkg::data_t rdata;
		bus_cycle(addr, data, 1'b1, rdata);
		if (addr >= 16'h7000 && addr <= 16'hB7FF)
			mem_model[addr] = data;	// VRAM and base RAM
		if (addr >= 16'h6800 && addr <= 16'h6FFF)
			io_written = data;
	endtask

	task automatic send_key(input laser310_kbd_pkg::scan_code_t code, input logic pressed);
		@(negedge CLK50MHZ);
		key_code = code;
		key_pressed = pressed;
		key_strobe = 1'b1;
		@(negedge CLK50MHZ);
		key_strobe = 1'b0;
	endtask

	task automatic check_reset_hold(input int exp_clocks);
		int n;
		int low_clocks;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge CLK50MHZ);
			if (!cpu_reset_n)
				break;
		end
		if (cpu_reset_n)
		begin
			$display("Timeout: CPU reset never went low after Ctrl+F12");
			timed_out = 1'b1;
			return;
		end
		low_clocks = 1;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge CLK50MHZ);
			if (cpu_reset_n)
				break;
			low_clocks++;
		end
		if (!cpu_reset_n)
		begin
			$display("Timeout: CPU reset stayed low");
			timed_out = 1'b1;
			return;
		end
		check_level("cpu_reset_n_o low clocks", low_clocks, exp_clocks);
	endtask

	task automatic check_interrupt(input int exp_low, input int exp_period);
		int n;
		int low_clocks;
		int period;
		logic prev;
		prev = cpu_int_n;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge CLK50MHZ);
			if (prev && !cpu_int_n)
				break;
			prev = cpu_int_n;
		end
		if (n == WAIT_LIMIT)
		begin
			$display("Timeout: no falling edge on the frame interrupt");
			timed_out = 1'b1;
			return;
		end
		low_clocks = 1;
		period = 0;
		prev = 1'b0;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge CLK50MHZ);
			period++;
			if (!cpu_int_n && period == low_clocks)
				low_clocks++;	// First low stretch only
			if (prev && !cpu_int_n)
				break;
			prev = cpu_int_n;
		end
		if (n == WAIT_LIMIT)
		begin
			$display("Timeout: second interrupt edge never came");
			timed_out = 1'b1;
			return;
		end
		check_level("cpu_int_n_o low clocks", low_clocks, exp_low);
		check_level("cpu_int_n_o period", period, exp_period);
	endtask

	initial
	begin
		int fd;
		int code;
		int i;
		int op_a;
		int op_b;
		logic [7:0] cmd;
		string line;
		laser310_mem_pkg::data_t rdata;
		seed = 96321;
		check_errors = 0;
		total_errors = 0;
		test_count = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		file_error = 1'b0;
		io_written = '0;
		RESET_N = 1'b0;
		cpu_addr = '0;
		cpu_do = '0;
		cpu_mreq = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		turbo = 1'b0;
		cass_in = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		repeat (3) @(negedge CLK50MHZ);
		RESET_N = 1'b1;
		repeat (4) @(negedge CLK50MHZ);	// Let the reset synchronizer settle
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("Cannot open stimulus file %s", STIM_FILE);
			file_error = 1'b1;
		end
		else
		begin
			while (!timed_out && $fscanf(fd, " %c", cmd) == 1)
			begin
				if (cmd == "#")
				begin
					code = $fgets(line, fd);
					continue;
				end
				check_errors = 0;
				op_a = 0;
				op_b = 0;
				case (cmd)
					"W", "R", "F", "V", "K", "I":
						code = $fscanf(fd, "%h %h", op_a, op_b);
					"S", "T", "X":
						code = $fscanf(fd, "%h", op_a);
					default:
						code = 0;
				endcase
				case (cmd)
					"W": write_byte(laser310_mem_pkg::addr_t'(op_a),
						laser310_mem_pkg::data_t'(op_b));
					"R":
					begin
						bus_cycle(laser310_mem_pkg::addr_t'(op_a), '0, 1'b0, rdata);
						check_data("cpu_di_o", rdata, laser310_mem_pkg::data_t'(op_b));
					end
					"F":
						for (i = 0; i < op_b && !timed_out; i++)
							write_byte(laser310_mem_pkg::addr_t'(op_a + i),
								laser310_mem_pkg::data_t'($random(seed)));
					"V":
						for (i = 0; i < op_b && !timed_out; i++)
						begin
							bus_cycle(laser310_mem_pkg::addr_t'(op_a + i), '0, 1'b0, rdata);
							check_data("cpu_di_o", rdata,
								mem_model[laser310_mem_pkg::addr_t'(op_a + i)]);
						end
					"K": send_key(laser310_kbd_pkg::scan_code_t'(op_a), op_b != 0);
					"S":
					begin
						@(negedge CLK50MHZ);
						turbo = (op_a != 0);
					end
					"T":
					begin
						@(negedge CLK50MHZ);
						cass_in = (op_a != 0);
					end
					"L":
					begin
						@(negedge CLK50MHZ);
						// Speaker gets bits 0 and 5, then cassette, AG and CSS
						check_latch("speaker_o,cass_out_o,vdg_ag_o,vdg_css_o",
							{speaker, cass_out, vdg_ag, vdg_css},
							{io_written[0], io_written[5], io_written[2],
							io_written[3], io_written[4]});
					end
					"I": check_interrupt(op_a, op_b);
					"X": check_reset_hold(op_a);
					default:
					begin
						$display("Unknown command %c in stimulus file", cmd);
						check_errors++;
					end
				endcase
				test_count++;
				if (check_errors != 0 || timed_out)
					failed_tests++;
				total_errors += check_errors;
				$display("Test %0d %c %h %h: %s", test_count, cmd, op_a, op_b,
					(check_errors == 0 && !timed_out) ? "ok" : "FAILED");
			end
			$fclose(fd);
		end
		$display("Tests run %0d, failed %0d, mismatches %0d", test_count, failed_tests,
			total_errors);
		if (failed_tests == 0 && test_count > 0 && !timed_out && !file_error)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
